//--- Bender.yml
package:
  name: zx_io

sources:
  # RTL in compile order
  - files:
      - design/zx_io_pkg.sv
      - design/joy_sync.sv
      - design/joy_mapper.sv
      - design/io_port_unit.sv
      - design/zx_io_top.sv

  # Testbench
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_zx_io.sv

# Top modules: tb_zx_io for simulation, zx_io_top for the RTL
# File list for direct simulator use: tb.f

//--- design/io_port_unit.sv
`default_nettype none

module io_port_unit (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  zx_io_pkg::cpu_bus_t   bus_i,
	input  zx_io_pkg::joy_map_t   map_i [zx_io_pkg::NUM_JOY],
	input  zx_io_pkg::key_row_t   key_data_i,  // Already ANDed over the selected rows
	input  wire                   tape_in_i,
	output zx_io_pkg::byte_t      rd_data_o,
	output zx_io_pkg::border_t    border_o,
	output logic                  ear_o,
	output logic                  mic_o
);
	import zx_io_pkg::*;

	// Sinclair stick order on a half-row
	// fire on bit 0, then up, down, right, left
	function automatic key_row_t sinclair_keys(input logic [4:0] j);
		return {j[1], j[0], j[2], j[3], j[4]};
	endfunction

	// ====================
	// Joystick merge
	// ====================
	joy_map_t map_or;

	always_comb begin
		map_or = '0;
		for (int j = 0; j < NUM_JOY; j++) begin
			map_or = map_or | map_i[j];
		end
	end

	// ====================
	// Keyboard mask
	// ====================
	key_row_t cursor_60;    // Keys 6 7 8 0
	key_row_t cursor_15;    // Key 5
	key_row_t row60_term;
	key_row_t row15_term;
	key_row_t joy_kbd;

	always_comb begin
		cursor_60 = {map_or.cursor[2], map_or.cursor[3], map_or.cursor[0], 1'b0,
			map_or.cursor[4]};
		cursor_15 = {map_or.cursor[1], 4'b0000};

		// A row not addressed by the CPU gets no joystick keys
		row60_term = {5{bus_i.addr[12]}} |
			~(sinclair_keys(map_or.sinclair1) | cursor_60);
		row15_term = {5{bus_i.addr[11]}} |
			~(sinclair_keys(map_or.sinclair2) | cursor_15);

		joy_kbd = row60_term & row15_term;
	end

	// ====================
	// ULA output port
	// ====================
	logic io_wr;
	logic io_rd;
	logic io_wr_q;   // Previous write strobe
	logic ula_wr;

	assign io_wr = bus_i.iorq & bus_i.wr & ~bus_i.m1;
	assign io_rd = bus_i.iorq & bus_i.rd & ~bus_i.m1;

	// Rising edge of the strobe on an even port
	assign ula_wr = io_wr & ~io_wr_q & ~bus_i.addr[0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q  <= 1'b0;
			border_o <= '0;
			ear_o    <= 1'b0;
			mic_o    <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
			if (ula_wr) begin
				border_o <= bus_i.dout[2:0];
				mic_o    <= bus_i.dout[3];
				ear_o    <= bus_i.dout[4];
			end
		end
	end

	// ====================
	// CPU read data
	// ====================
	always_comb begin
		rd_data_o = PORT_IDLE;
		if (io_rd) begin
			if (bus_i.addr[5:0] == KEMPSTON_PORT) begin
				rd_data_o = {2'b00, map_or.kempston};
			end else if (!bus_i.addr[0]) begin
				// EAR output feeds back into the tape bit
				rd_data_o = {1'b1, tape_in_i | ear_o, 1'b1, key_data_i & joy_kbd};
			end
		end
	end

endmodule

`default_nettype wire

//--- design/joy_mapper.sv
`default_nettype none

module joy_mapper (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  zx_io_pkg::joy_bits_t  joy_i,
	input  zx_io_pkg::joy_mode_e  mode_i,
	output zx_io_pkg::joy_map_t   map_o
);
	import zx_io_pkg::*;

	joy_map_t map_d;

	// Steer the buttons into one field
	always_comb begin
		map_d = '0;
		case (mode_i)
			JOY_SINCLAIR1: map_d.sinclair1 = joy_i[4:0];
			JOY_SINCLAIR2: map_d.sinclair2 = joy_i[4:0];
			JOY_KEMPSTON:  map_d.kempston  = joy_i;      // Fire 2 only here
			JOY_CURSOR:    map_d.cursor    = joy_i[4:0];
			default:       map_d = '0;
		endcase
	end

	// One cycle of latency
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			map_o <= '0;
		end else begin
			map_o <= map_d;
		end
	end

endmodule

`default_nettype wire

//--- design/joy_sync.sv
`default_nettype none

// Joystick pads are asynchronous to clk_sys
module joy_sync (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  zx_io_pkg::joy_bits_t   joy_i  [zx_io_pkg::NUM_JOY],
	input  zx_io_pkg::joy_mode_e   mode_i [zx_io_pkg::NUM_JOY],
	output zx_io_pkg::joy_bits_t   joy_o  [zx_io_pkg::NUM_JOY],
	output zx_io_pkg::joy_mode_e   mode_o [zx_io_pkg::NUM_JOY]
);
	import zx_io_pkg::*;

	// Stage 0 samples the pad and the last stage drives the outputs
	joy_bits_t joy_q  [SYNC_STAGES][NUM_JOY];
	joy_mode_e mode_q [SYNC_STAGES][NUM_JOY];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int s = 0; s < SYNC_STAGES; s++) begin
				for (int j = 0; j < NUM_JOY; j++) begin
					joy_q[s][j]  <= '0;
					mode_q[s][j] <= JOY_SINCLAIR1;  // Default mode
				end
			end
		end else begin
			joy_q[0]  <= joy_i;
			mode_q[0] <= mode_i;
			for (int s = 1; s < SYNC_STAGES; s++) begin
				joy_q[s]  <= joy_q[s-1];
				mode_q[s] <= mode_q[s-1];
			end
		end
	end

	assign joy_o  = joy_q[SYNC_STAGES-1];
	assign mode_o = mode_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- design/zx_io_pkg.sv
`default_nettype none

package zx_io_pkg;

	// ====================
	// Sizes
	// ====================
	localparam int NUM_JOY     = 2;  // Joystick ports on the host
	localparam int SYNC_STAGES = 2;  // Flops per input synchronizer

	// ====================
	// Plain vector types
	// ====================
	typedef logic [15:0] addr_t;     // Z80 address
	typedef logic [7:0]  byte_t;
	typedef logic [2:0]  border_t;   // GRB border colour

	// One keyboard half-row where a pressed key reads 0
	typedef logic [4:0]  key_row_t;

	// Active high buttons
	// 0 right, 1 left, 2 down, 3 up, 4 fire, 5 fire 2
	typedef logic [5:0]  joy_bits_t;

	// Emulation mode per joystick
	typedef enum logic [1:0] {
		JOY_SINCLAIR1 = 2'd0,
		JOY_SINCLAIR2 = 2'd1,
		JOY_KEMPSTON  = 2'd2,
		JOY_CURSOR    = 2'd3
	} joy_mode_e;

	// ====================
	// Bundles
	// ====================
	// Only the field of the selected mode is non-zero
	typedef struct packed {
		joy_bits_t   kempston;
		logic [4:0]  sinclair1;   // Low 5 joystick bits
		logic [4:0]  sinclair2;
		logic [4:0]  cursor;
	} joy_map_t;

	// CPU bus, active high levels
	typedef struct packed {
		addr_t addr;
		byte_t dout;    // CPU write data
		logic  iorq;
		logic  rd;
		logic  wr;
		logic  m1;
	} cpu_bus_t;

	// Port decode
	localparam logic [5:0] KEMPSTON_PORT = 6'h1F;  // Low address bits only
	localparam byte_t      PORT_IDLE     = 8'hFF;  // Floating bus value

endpackage

`default_nettype wire

//--- design/zx_io_top.sv
`default_nettype none

module zx_io_top (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  zx_io_pkg::cpu_bus_t   bus_i,
	input  zx_io_pkg::joy_bits_t  joy_i  [zx_io_pkg::NUM_JOY],
	input  zx_io_pkg::joy_mode_e  mode_i [zx_io_pkg::NUM_JOY],
	input  zx_io_pkg::key_row_t   key_data_i,
	input  wire                   tape_in_i,
	output zx_io_pkg::byte_t      rd_data_o,
	output zx_io_pkg::border_t    border_o,
	output logic                  ear_o,
	output logic                  mic_o
);
	import zx_io_pkg::*;

	joy_bits_t joy_s  [NUM_JOY];   // Synchronized buttons
	joy_mode_e mode_s [NUM_JOY];
	joy_map_t  map    [NUM_JOY];   // One map per port

	joy_sync u_sync (
		.clk_sys (clk_sys),
		.reset   (reset),
		.joy_i   (joy_i),
		.mode_i  (mode_i),
		.joy_o   (joy_s),
		.mode_o  (mode_s)
	);

	// ====================
	// Per port mapping
	// ====================
	for (genvar j = 0; j < NUM_JOY; j++) begin : g_joy
		joy_mapper u_mapper (
			.clk_sys (clk_sys),
			.reset   (reset),
			.joy_i   (joy_s[j]),
			.mode_i  (mode_s[j]),
			.map_o   (map[j])
		);
	end

	io_port_unit u_ports (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus_i      (bus_i),
		.map_i      (map),
		.key_data_i (key_data_i),
		.tape_in_i  (tape_in_i),
		.rd_data_o  (rd_data_o),
		.border_o   (border_o),
		.ear_o      (ear_o),
		.mic_o      (mic_o)
	);

endmodule

`default_nettype wire

//--- tb.f
+incdir+verif
design/zx_io_pkg.sv
design/joy_sync.sv
design/joy_mapper.sv
design/io_port_unit.sv
design/zx_io_top.sv
verif/tb_zx_io.sv

//--- verif/zx_io_model.svh
`ifndef ZX_IO_MODEL_SVH
`define ZX_IO_MODEL_SVH

// ====================
// Random stimulus
// ====================
localparam logic [31:0] LFSR_SEED = 32'h70f9;
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

logic [31:0] lfsr_state = LFSR_SEED;

// One Galois shift to the right
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0]) begin
		return (s >> 1) ^ LFSR_TAPS;
	end
	return s >> 1;
endfunction

// LFSR is stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

// ====================
// Expected responses
// ====================
// Buttons of all ports ORed into the field of each mode
function automatic joy_map_t merged_map(input joy_bits_t j [NUM_JOY],
	input joy_mode_e m [NUM_JOY]);
	joy_map_t r;
	r = '0;
	for (int p = 0; p < NUM_JOY; p++) begin
		case (m[p])
			JOY_SINCLAIR1: r.sinclair1 |= j[p][4:0];
			JOY_SINCLAIR2: r.sinclair2 |= j[p][4:0];
			JOY_KEMPSTON:  r.kempston  |= j[p];
			default:       r.cursor    |= j[p][4:0];
		endcase
	end
	return r;
endfunction

// Button bits 0 right, 1 left, 2 down, 3 up, 4 fire
function automatic key_row_t key_mask(input addr_t addr, input joy_map_t m);
	key_row_t row60;
	key_row_t row15;
	row60 = '1;
	row15 = '1;
	if (!addr[12]) begin
		row60[0] = ~(m.sinclair1[4] | m.cursor[4]);  // Fire on key 0
		row60[1] = ~m.sinclair1[3];
		row60[2] = ~(m.sinclair1[2] | m.cursor[0]);
		row60[3] = ~(m.sinclair1[0] | m.cursor[3]);
		row60[4] = ~(m.sinclair1[1] | m.cursor[2]);
	end
	if (!addr[11]) begin
		row15[0] = ~m.sinclair2[4];
		row15[1] = ~m.sinclair2[3];
		row15[2] = ~m.sinclair2[2];
		row15[3] = ~m.sinclair2[0];
		row15[4] = ~(m.sinclair2[1] | m.cursor[1]);  // Cursor left is key 5
	end
	return row60 & row15;
endfunction

// Data seen by the CPU during an active I/O read
function automatic byte_t expected_read(input addr_t addr, input key_row_t key,
	input logic tape, input logic ear_q, input joy_map_t m);
	if (addr[5:0] == KEMPSTON_PORT) begin
		return {2'b00, m.kempston};
	end
	if (!addr[0]) begin
		return {1'b1, tape | ear_q, 1'b1, key & key_mask(addr, m)};
	end
	return PORT_IDLE;
endfunction

`endif

//--- verif/tb_zx_io.sv
`default_nettype none

module tb_zx_io;
	timeunit 1ns;
	timeprecision 100ps;

	import zx_io_pkg::*;

	`include "zx_io_model.svh"

	localparam int SETTLE_CYCLES = 5;   // Sync plus mapper latency with margin
	localparam int RAND_READS    = 40;

	logic      clk_sys = 1'b0;
	logic      reset;
	cpu_bus_t  bus;
	joy_bits_t joy  [NUM_JOY];
	joy_mode_e mode [NUM_JOY];
	key_row_t  key_data;
	logic      tape_in;
	byte_t     rd_data;
	border_t   border;
	logic      ear;
	logic      mic;

	// Expected ULA port contents
	border_t   exp_border;
	logic      exp_ear;
	logic      exp_mic;

	always #2 clk_sys = ~clk_sys;

	zx_io_top uut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus_i      (bus),
		.joy_i      (joy),
		.mode_i     (mode),
		.key_data_i (key_data),
		.tape_in_i  (tape_in),
		.rd_data_o  (rd_data),
		.border_o   (border),
		.ear_o      (ear),
		.mic_o      (mic)
	);

	task automatic fail_value(input string name, input byte_t want, input byte_t got);
		$display("error %s: expected %02h, actual %02h", name, want, got);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	// Floating bus whenever no I/O read is active
	assert property (@(posedge clk_sys) disable iff (reset)
		!(bus.iorq && bus.rd && !bus.m1) |-> rd_data == PORT_IDLE)
		else fail_value("idle_bus", PORT_IDLE, $sampled(rd_data));

	// Inputs change 1 ns after the edge
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic settle(input int cycles);
		repeat (cycles) tick();
	endtask

	task automatic check_ula(input string name);
		assert ({ear, mic, border} === {exp_ear, exp_mic, exp_border})
			else fail_value(name, {3'b000, exp_ear, exp_mic, exp_border},
				{3'b000, ear, mic, border});
	endtask

	task automatic check_read(input string name, input addr_t addr, input logic m1);
		byte_t want;
		bus      = '0;
		bus.addr = addr;
		bus.iorq = 1'b1;
		bus.rd   = 1'b1;
		bus.m1   = m1;
		if (m1) begin
			want = PORT_IDLE;
		end else begin
			want = expected_read(addr, key_data, tape_in, exp_ear, merged_map(joy, mode));
		end
		#1;
		assert (rd_data === want) else fail_value(name, want, rd_data);
		tick();
		bus = '0;
	endtask

	// Write, then hold the same strobe with other data
	task automatic ula_write(input addr_t addr, input byte_t data);
		bus      = '0;
		bus.addr = addr;
		bus.dout = data;
		bus.iorq = 1'b1;
		bus.wr   = 1'b1;
		if (!addr[0]) begin
			exp_border = data[2:0];
			exp_mic    = data[3];
			exp_ear    = data[4];
		end
		tick();
		check_ula("ula_write");
		bus.dout = ~data;
		tick();
		check_ula("ula_hold");
		bus = '0;
		tick();
	endtask

	initial begin
		addr_t addr;
		reset      = 1'b1;
		bus        = '0;
		key_data   = '1;
		tape_in    = 1'b0;
		exp_border = '0;
		exp_ear    = 1'b0;
		exp_mic    = 1'b0;
		for (int j = 0; j < NUM_JOY; j++) begin
			joy[j]  = '0;
			mode[j] = JOY_SINCLAIR1;
		end
		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// ====================
		// Reset and idle bus
		// ====================
		check_ula("reset_state");
		check_read("m1_cycle", 16'h00FE, 1'b1);
		check_read("odd_port", 16'h00FF, 1'b0);

		// ULA writes around an ignored odd port
		ula_write(16'h00FE, 8'h15);
		ula_write(16'h00FF, 8'h0A);
		ula_write(16'h00FE, 8'h0A);
		ula_write(16'h00FE, 8'h00);

		// ====================
		// Sinclair I and II
		// ====================
		for (int i = 0; i < RAND_READS; i++) begin
			for (int j = 0; j < NUM_JOY; j++) begin
				joy[j]  = joy_bits_t'(rand_bits(6));
				mode[j] = (rand_bits(1) != 0) ? JOY_SINCLAIR2 : JOY_SINCLAIR1;
			end
			key_data = key_row_t'(rand_bits(5));
			tape_in  = 1'(rand_bits(1));
			settle(SETTLE_CYCLES);
			addr     = 16'hE7FE;
			addr[11] = 1'(rand_bits(1));
			addr[12] = 1'(rand_bits(1));
			check_read("sinclair", addr, 1'b0);
		end

		// Kempston on one or both ports
		for (int i = 0; i < 12; i++) begin
			for (int j = 0; j < NUM_JOY; j++) begin
				joy[j] = joy_bits_t'(rand_bits(6));
			end
			mode[0]  = JOY_KEMPSTON;
			mode[1]  = i[0] ? JOY_KEMPSTON : JOY_SINCLAIR1;
			key_data = key_row_t'(rand_bits(5));
			settle(SETTLE_CYCLES);
			check_read("kempston", 16'h001F, 1'b0);
			check_read("kempston_keys", 16'hE7FE, 1'b0);
		end

		// Cursor keys on both half-rows
		for (int i = 0; i < 12; i++) begin
			for (int j = 0; j < NUM_JOY; j++) begin
				joy[j] = joy_bits_t'(rand_bits(6));
			end
			mode[0]  = JOY_CURSOR;
			mode[1]  = i[0] ? JOY_CURSOR : JOY_SINCLAIR2;
			key_data = key_row_t'(rand_bits(5));
			tape_in  = 1'(rand_bits(1));
			settle(SETTLE_CYCLES);
			check_read("cursor_60", 16'hEFFE, 1'b0);
			check_read("cursor_15", 16'hF7FE, 1'b0);
		end

		// ====================
		// Tape bit
		// ====================
		tape_in = 1'b0;
		ula_write(16'h00FE, 8'h10);
		check_read("ear_loop", 16'hFFFE, 1'b0);
		ula_write(16'h00FE, 8'h07);
		check_read("tape_low", 16'hFFFE, 1'b0);
		tape_in = 1'b1;
		check_read("tape_high", 16'hFFFE, 1'b0);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
